//--- myo_control.f
+incdir+rtl
rtl/myo_pkg.sv
rtl/myo_registers.sv
rtl/motor_scheduler.sv
rtl/spi_frame_master.sv
rtl/pd_controller.sv
rtl/myo_control.sv
tests/myo_control_sva.sv
tests/myo_control_tb.sv

//--- rtl/motor_scheduler.sv
`timescale 1ns/1ps
`include "myo_control_params.svh"

module motor_scheduler (
	input logic clock,
	input logic reset,
	input logic run_i,
	input myo_pkg::motor_config_t [`MYO_MOTORS-1:0] config_i,
	input logic mirrored_i,
	input logic frame_done_i,
	input myo_pkg::feedback_t rx_feedback_i,
	input logic calc_valid_i,
	input myo_pkg::pwm_t calc_pwm_i,
	input myo_pkg::position_t calc_err_i,
	output logic frame_start_o,
	output myo_pkg::pwm_t tx_pwm_o,
	output myo_pkg::motor_idx_t motor_o,
	output logic calc_start_o,
	output myo_pkg::motor_config_t calc_config_o,
	output myo_pkg::position_t calc_feedback_o,
	output myo_pkg::position_t calc_prev_err_o,
	output myo_pkg::motor_status_t [`MYO_MOTORS-1:0] status_o
);

	myo_pkg::sched_state_e state;
	myo_pkg::motor_idx_t next_motor;
	myo_pkg::displacement_t rx_disp;
	myo_pkg::position_t disp_ext;
	// last control error of every motor, needed for the derivative term
	myo_pkg::position_t [`MYO_MOTORS-1:0] prev_err;

	// round robin over the motors on the bus
	assign next_motor = (motor_o == `MYO_MOTORS - 1) ? '0 : motor_o + 8'd1;

	// a mirrored muscle unit sees its spring compressed the other way round
	assign rx_disp = mirrored_i ? -rx_feedback_i.displacement : rx_feedback_i.displacement;
	// widened with sign so displacement mode shares the 32-bit datapath
	assign disp_ext = rx_disp;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= myo_pkg::SCHED_IDLE;
			motor_o <= '0;
			frame_start_o <= 1'b0;
			tx_pwm_o <= '0;
			calc_start_o <= 1'b0;
			calc_config_o <= '0;
			calc_feedback_o <= '0;
			calc_prev_err_o <= '0;
			status_o <= '0;
			prev_err <= '0;
		end else begin
			// start strobes are single cycle pulses
			frame_start_o <= 1'b0;
			calc_start_o <= 1'b0;
			case (state)
				myo_pkg::SCHED_IDLE: begin
					// resume the sweep at the motor where it stopped
					if (run_i) begin
						frame_start_o <= 1'b1;
						tx_pwm_o <= status_o[motor_o].pwm_ref;
						state <= myo_pkg::SCHED_FRAME;
					end
				end
				myo_pkg::SCHED_FRAME: begin
					if (frame_done_i) begin
						status_o[motor_o].position <= rx_feedback_i.position;
						status_o[motor_o].displacement <= rx_disp;
						// hand the fresh sample to the PD pipeline right away
						calc_start_o <= 1'b1;
						calc_config_o <= config_i[motor_o];
						if (config_i[motor_o].mode == myo_pkg::MODE_DISPLACEMENT) begin
							calc_feedback_o <= disp_ext;
						end else begin
							calc_feedback_o <= rx_feedback_i.position;
						end
						calc_prev_err_o <= prev_err[motor_o];
						state <= myo_pkg::SCHED_COMPUTE;
					end
				end
				myo_pkg::SCHED_COMPUTE: begin
					if (calc_valid_i) begin
						// the new reference goes out in this motor's next frame
						status_o[motor_o].pwm_ref <= calc_pwm_i;
						prev_err[motor_o] <= calc_err_i;
						motor_o <= next_motor;
						// clearing run stops the sweep here, between two frames
						if (run_i) begin
							frame_start_o <= 1'b1;
							tx_pwm_o <= status_o[next_motor].pwm_ref;
							state <= myo_pkg::SCHED_FRAME;
						end else begin
							state <= myo_pkg::SCHED_IDLE;
						end
					end
				end
				default: state <= myo_pkg::SCHED_IDLE;
			endcase
		end
	end

endmodule

//--- rtl/myo_control.sv
`timescale 1ns/1ps
`include "myo_control_params.svh"

module myo_control (
	input logic clock,
	input logic reset,
	input myo_pkg::bus_addr_t address_i,
	input logic write_i,
	input myo_pkg::bus_data_t writedata_i,
	input logic read_i,
	input logic miso_i,
	input logic mirrored_muscle_unit_i,
	output myo_pkg::bus_data_t readdata_o,
	output logic waitrequest_o,
	output logic [`MYO_MOTORS-1:0] ss_n_o,
	output logic sck_o,
	output logic mosi_o
);

	myo_pkg::motor_config_t [`MYO_MOTORS-1:0] config_bank;
	myo_pkg::motor_status_t [`MYO_MOTORS-1:0] status_bank;
	logic run;
	logic frame_start;
	logic frame_done;
	logic frame_ss_n;
	myo_pkg::pwm_t tx_pwm;
	myo_pkg::feedback_t rx_feedback;
	myo_pkg::motor_idx_t motor;
	logic calc_start;
	logic calc_valid;
	myo_pkg::motor_config_t calc_config;
	myo_pkg::position_t calc_feedback;
	myo_pkg::position_t calc_prev_err;
	myo_pkg::pwm_t calc_pwm;
	myo_pkg::position_t calc_err;

	// host side register bank
	myo_registers u_registers (
		.clock(clock),
		.reset(reset),
		.address_i(address_i),
		.write_i(write_i),
		.writedata_i(writedata_i),
		.read_i(read_i),
		.status_i(status_bank),
		.readdata_o(readdata_o),
		.waitrequest_o(waitrequest_o),
		.config_o(config_bank),
		.run_o(run)
	);

	// sweeps the motors and sequences frame, controller, next frame
	motor_scheduler u_scheduler (
		.clock(clock),
		.reset(reset),
		.run_i(run),
		.config_i(config_bank),
		.mirrored_i(mirrored_muscle_unit_i),
		.frame_done_i(frame_done),
		.rx_feedback_i(rx_feedback),
		.calc_valid_i(calc_valid),
		.calc_pwm_i(calc_pwm),
		.calc_err_i(calc_err),
		.frame_start_o(frame_start),
		.tx_pwm_o(tx_pwm),
		.motor_o(motor),
		.calc_start_o(calc_start),
		.calc_config_o(calc_config),
		.calc_feedback_o(calc_feedback),
		.calc_prev_err_o(calc_prev_err),
		.status_o(status_bank)
	);

	spi_frame_master u_spi (
		.clock(clock),
		.reset(reset),
		.start_i(frame_start),
		.tx_pwm_i(tx_pwm),
		.miso_i(miso_i),
		.done_o(frame_done),
		.rx_o(rx_feedback),
		.ss_n_o(frame_ss_n),
		.sck_o(sck_o),
		.mosi_o(mosi_o)
	);

	// one controller is shared by all motors in turn
	pd_controller u_pd (
		.clock(clock),
		.reset(reset),
		.start_i(calc_start),
		.config_i(calc_config),
		.feedback_i(calc_feedback),
		.prev_err_i(calc_prev_err),
		.valid_o(calc_valid),
		.pwm_o(calc_pwm),
		.err_o(calc_err)
	);

	// the frame select reaches only the board of the current motor
	always_comb begin
		for (int m = 0; m < `MYO_MOTORS; m++) begin
			ss_n_o[m] = (motor == myo_pkg::motor_idx_t'(m)) ? frame_ss_n : 1'b1;
		end
	end

endmodule

//--- rtl/myo_control_params.svh
`ifndef MYO_CONTROL_PARAMS_SVH
`define MYO_CONTROL_PARAMS_SVH

// number of motor boards sharing the SPI bus, each with its own slave select
`define MYO_MOTORS 4

// PD sum is divided by 2**MYO_GAIN_SHIFT so gains act as 8.8 fixed point
`define MYO_GAIN_SHIFT 8
// largest PWM magnitude the motor boards accept
`define MYO_PWM_MAX 32767

// clock cycles per sck half period
`define MYO_SPI_HALF 4
// a frame is a fixed number of 16-bit words
`define MYO_WORD_BITS 16
`define MYO_FRAME_WORDS 4
`define MYO_FRAME_BITS (`MYO_FRAME_WORDS * `MYO_WORD_BITS)

// value selectors, placed in the upper byte of the bus address
`define MYO_ADDR_KP 8'h00
`define MYO_ADDR_KD 8'h02
`define MYO_ADDR_SP 8'h03
`define MYO_ADDR_LIMIT 8'h04
`define MYO_ADDR_MODE 8'h05
`define MYO_ADDR_POSITION 8'h06
`define MYO_ADDR_RUN 8'h07
`define MYO_ADDR_DISPLACEMENT 8'h09
`define MYO_ADDR_PWM 8'h0A

// returned for an unmapped selector or a motor index out of range
`define MYO_BAD_READ 32'hDEADBEEF

`endif

//--- rtl/myo_pkg.sv
package myo_pkg;

	// bus side widths
	typedef logic [15:0] bus_addr_t;
	typedef logic [31:0] bus_data_t;
	typedef logic [7:0] motor_idx_t;

	// controller quantities, all two's complement
	typedef logic signed [31:0] gain_t;
	typedef logic signed [31:0] position_t;
	typedef logic signed [15:0] displacement_t;
	typedef logic signed [15:0] pwm_t;

	// one word on the SPI wire
	typedef logic [15:0] spi_word_t;

	// selects which feedback the PD law regulates
	// codes other than displacement fall back to position control
	typedef enum logic [2:0] {
		MODE_POSITION = 3'd0,
		MODE_DISPLACEMENT = 3'd1
	} control_mode_e;

	// per-motor settings written by the host
	typedef struct packed {
		gain_t kp;
		gain_t kd;
		position_t setpoint;
		position_t limit;
		control_mode_e mode;
	} motor_config_t;

	// per-motor values the host can read back
	typedef struct packed {
		position_t position;
		displacement_t displacement;
		pwm_t pwm_ref;
	} motor_status_t;

	// what one SPI frame brings back from a motor board
	typedef struct packed {
		position_t position;
		displacement_t displacement;
	} feedback_t;

	typedef enum logic [1:0] {
		SCHED_IDLE,
		SCHED_FRAME,
		SCHED_COMPUTE
	} sched_state_e;

	typedef enum logic [1:0] {
		SPI_IDLE,
		SPI_SHIFT,
		SPI_DONE
	} spi_state_e;

endpackage

//--- rtl/myo_registers.sv
`timescale 1ns/1ps
`include "myo_control_params.svh"

module myo_registers (
	input logic clock,
	input logic reset,
	input myo_pkg::bus_addr_t address_i,
	input logic write_i,
	input myo_pkg::bus_data_t writedata_i,
	input logic read_i,
	input myo_pkg::motor_status_t [`MYO_MOTORS-1:0] status_i,
	output myo_pkg::bus_data_t readdata_o,
	output logic waitrequest_o,
	output myo_pkg::motor_config_t [`MYO_MOTORS-1:0] config_o,
	output logic run_o
);

	logic [7:0] sel;
	myo_pkg::motor_idx_t idx;
	logic in_range;
	logic wait_flag;
	myo_pkg::motor_config_t [`MYO_MOTORS-1:0] config_q;
	logic run_q;

	// upper byte picks the value, lower byte picks the motor
	assign sel = address_i[15:8];
	assign idx = address_i[7:0];
	assign in_range = (idx < `MYO_MOTORS);

	assign config_o = config_q;
	assign run_o = run_q;

	// a read stalls for exactly one cycle while the mux output is registered
	assign waitrequest_o = read_i && wait_flag;

	// wait_flag drops after the first read cycle and rearms when the host
	// completes the read by sampling waitrequest low
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			wait_flag <= 1'b1;
		end else begin
			wait_flag <= !(read_i && wait_flag);
		end
	end

	// writes never stall, they land on the edge where write_i is seen
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			config_q <= '0;
			run_q <= 1'b0;
		end else if (write_i) begin
			// run is global so the motor byte is a don't care
			if (sel == `MYO_ADDR_RUN) begin
				run_q <= (writedata_i != '0);
			end else if (in_range) begin
				case (sel)
					`MYO_ADDR_KP: config_q[idx].kp <= writedata_i;
					`MYO_ADDR_KD: config_q[idx].kd <= writedata_i;
					`MYO_ADDR_SP: config_q[idx].setpoint <= writedata_i;
					`MYO_ADDR_LIMIT: config_q[idx].limit <= writedata_i;
					`MYO_ADDR_MODE: config_q[idx].mode <= myo_pkg::control_mode_e'(writedata_i[2:0]);
					// feedback and pwm values are read only, other codes unmapped
					default: ;
				endcase
			end
		end
	end

	// read data is captured in the stall cycle and held until the next read
	always_ff @(posedge clock) begin
		if (read_i && wait_flag) begin
			if (sel == `MYO_ADDR_RUN) begin
				readdata_o <= {31'b0, run_q};
			end else if (!in_range) begin
				readdata_o <= `MYO_BAD_READ;
			end else begin
				case (sel)
					`MYO_ADDR_KP: readdata_o <= config_q[idx].kp;
					`MYO_ADDR_KD: readdata_o <= config_q[idx].kd;
					`MYO_ADDR_SP: readdata_o <= config_q[idx].setpoint;
					`MYO_ADDR_LIMIT: readdata_o <= config_q[idx].limit;
					`MYO_ADDR_MODE: readdata_o <= {29'b0, config_q[idx].mode};
					`MYO_ADDR_POSITION: readdata_o <= status_i[idx].position;
					// 16-bit signed values are sign extended onto the bus
					`MYO_ADDR_DISPLACEMENT: readdata_o <= {{16{status_i[idx].displacement[15]}},
						status_i[idx].displacement};
					`MYO_ADDR_PWM: readdata_o <= {{16{status_i[idx].pwm_ref[15]}},
						status_i[idx].pwm_ref};
					default: readdata_o <= `MYO_BAD_READ;
				endcase
			end
		end
	end

endmodule

//--- rtl/pd_controller.sv
`timescale 1ns/1ps
`include "myo_control_params.svh"

module pd_controller (
	input logic clock,
	input logic reset,
	input logic start_i,
	input myo_pkg::motor_config_t config_i,
	input myo_pkg::position_t feedback_i,
	input myo_pkg::position_t prev_err_i,
	output logic valid_o,
	output myo_pkg::pwm_t pwm_o,
	output myo_pkg::position_t err_o
);

	logic valid1;
	myo_pkg::position_t err_now;
	myo_pkg::position_t err1;
	myo_pkg::position_t derr1;
	myo_pkg::position_t limit1;
	myo_pkg::gain_t kp1;
	myo_pkg::gain_t kd1;
	logic signed [63:0] sum;
	logic signed [63:0] scaled;
	logic signed [63:0] lim_abs;
	logic signed [63:0] cap;
	logic signed [63:0] clamped;

	assign err_now = config_i.setpoint - feedback_i;

	// two stage pipeline, a new start may enter every cycle
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			valid1 <= 1'b0;
			valid_o <= 1'b0;
		end else begin
			valid1 <= start_i;
			valid_o <= valid1;
		end
	end

	always_ff @(posedge clock) begin
		// stage 1 forms the error terms and carries the gains along
		if (start_i) begin
			err1 <= err_now;
			derr1 <= err_now - prev_err_i;
			kp1 <= config_i.kp;
			kd1 <= config_i.kd;
			limit1 <= config_i.limit;
		end
		// stage 2 registers the clamped result, the error becomes next prev_err
		if (valid1) begin
			pwm_o <= clamped[15:0];
			err_o <= err1;
		end
	end

	always_comb begin
		// products kept at full 64-bit width so no term wraps before the shift
		sum = 64'(kp1) * 64'(err1) + 64'(kd1) * 64'(derr1);
		scaled = sum >>> `MYO_GAIN_SHIFT;
		// limit is a magnitude, its sign is ignored
		lim_abs = (limit1 < 0) ? -64'(limit1) : 64'(limit1);
		cap = (lim_abs > `MYO_PWM_MAX) ? 64'(`MYO_PWM_MAX) : lim_abs;
		if (scaled > cap) begin
			clamped = cap;
		end else if (scaled < -cap) begin
			clamped = -cap;
		end else begin
			clamped = scaled;
		end
	end

endmodule

//--- rtl/spi_frame_master.sv
`timescale 1ns/1ps
`include "myo_control_params.svh"

module spi_frame_master (
	input logic clock,
	input logic reset,
	input logic start_i,
	input myo_pkg::pwm_t tx_pwm_i,
	input logic miso_i,
	output logic done_o,
	output myo_pkg::feedback_t rx_o,
	output logic ss_n_o,
	output logic sck_o,
	output logic mosi_o
);

	localparam int HALF = `MYO_SPI_HALF;
	localparam int W = `MYO_WORD_BITS;
	localparam int BITS = `MYO_FRAME_BITS;

	myo_pkg::spi_state_e state;
	logic [$clog2(HALF)-1:0] div_cnt;
	logic [$clog2(BITS)-1:0] bit_cnt;
	// one register serves both directions, bits leave at the top and
	// miso enters at the bottom
	logic [BITS-1:0] shreg;
	myo_pkg::spi_word_t tx_word;
	myo_pkg::spi_word_t pos_hi;
	myo_pkg::spi_word_t pos_lo;
	myo_pkg::spi_word_t disp_word;

	assign tx_word = tx_pwm_i;

	// word 0 coming back is a status word the hub does not use
	assign pos_hi = shreg[BITS-1-W -: W];
	assign pos_lo = shreg[BITS-1-2*W -: W];
	assign disp_word = shreg[BITS-1-3*W -: W];
	assign rx_o.position = {pos_hi, pos_lo};
	assign rx_o.displacement = disp_word;

	// one cycle after the last sck fall
	assign done_o = (state == myo_pkg::SPI_DONE);

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= myo_pkg::SPI_IDLE;
			div_cnt <= '0;
			bit_cnt <= '0;
			shreg <= '0;
			ss_n_o <= 1'b1;
			sck_o <= 1'b0;
			mosi_o <= 1'b0;
		end else begin
			case (state)
				myo_pkg::SPI_IDLE: begin
					if (start_i) begin
						// pwm reference first, the remaining words are padding
						shreg <= {tx_word, {(BITS-W){1'b0}}};
						div_cnt <= '0;
						bit_cnt <= '0;
						ss_n_o <= 1'b0;
						state <= myo_pkg::SPI_SHIFT;
					end
				end
				myo_pkg::SPI_SHIFT: begin
					if (div_cnt == HALF - 1) begin
						div_cnt <= '0;
						sck_o <= !sck_o;
						if (!sck_o) begin
							// rising edge, present the next bit for the slave
							mosi_o <= shreg[BITS-1];
						end else begin
							// falling edge, capture miso and advance
							shreg <= {shreg[BITS-2:0], miso_i};
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == BITS - 1) begin
								ss_n_o <= 1'b1;
								mosi_o <= 1'b0;
								state <= myo_pkg::SPI_DONE;
							end
						end
					end else begin
						div_cnt <= div_cnt + 1'b1;
					end
				end
				myo_pkg::SPI_DONE: state <= myo_pkg::SPI_IDLE;
				default: state <= myo_pkg::SPI_IDLE;
			endcase
		end
	end

endmodule

//--- run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root
# the exit status is nonzero when the build fails or the run ends in $fatal

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module myo_control_tb -f myo_control.f -o myo_control_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/myo_control_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi
exit 0

//--- tests/myo_control_input.txt
// first word: mirrored muscle unit flag, applied to every motor
// then one line per motor, all hex: motor kp kd setpoint limit mode position displacement exp_pwm
00000001
00000000 00000200 00000080 000003E8 00004E20 00000000 00000258 00000032 000003E8
00000001 00000100 00000100 00000064 00007530 00000001 00012345 0000001E 00000104
00000002 00001000 00000000 00000000 FFFFEC78 00000000 FFFFF830 00000000 00001388
00000003 00000180 00000040 FFFFFE0C 000186A0 00000001 7FFF0000 00000100 FFFFFE55

//--- tests/myo_control_sva.sv
`timescale 1ns/1ps
`include "myo_control_params.svh"

module myo_control_sva (
	input logic clock,
	input logic reset,
	input logic read_i,
	input logic waitrequest_i,
	input logic [`MYO_MOTORS-1:0] ss_n_i,
	input logic sck_i
);

	// the shared SPI bus may only ever address one motor board, and a select
	// stays on the same board until it is released
	one_select: assert property (@(posedge clock) disable iff (reset)
		$onehot0(~ss_n_i) && ((&ss_n_i) || (&$past(ss_n_i)) || (ss_n_i == $past(ss_n_i))))
		else $error("slave selects overlap or switch boards without a release");

	// the bus only stalls a read that the host is actually making, and only once
	wait_needs_read: assert property (@(posedge clock) disable iff (reset)
		waitrequest_i |-> (read_i && !$past(waitrequest_i)))
		else $error("waitrequest high without a read or for more than one cycle");

	// sck idles low whenever no board is selected
	sck_idle: assert property (@(posedge clock) disable iff (reset)
		(&ss_n_i) |-> !sck_i)
		else $error("sck toggles with no slave selected");

endmodule

bind myo_control myo_control_sva u_sva (
	.clock(clock),
	.reset(reset),
	.read_i(read_i),
	.waitrequest_i(waitrequest_o),
	.ss_n_i(ss_n_o),
	.sck_i(sck_o)
);

//--- tests/myo_control_tb.sv
`timescale 1ns/1ps
`include "myo_control_params.svh"

module myo_control_tb;

	localparam int MOTORS = `MYO_MOTORS;
	localparam int COLUMNS = 9;
	localparam int FRAME_LEN = 2 * `MYO_SPI_HALF * `MYO_FRAME_BITS + 1;
	// one wait may span a few frames plus the bus traffic around them
	localparam int WAIT_LIMIT = 6 * FRAME_LEN;

	logic clock;
	logic reset;
	myo_pkg::bus_addr_t address;
	logic write_en;
	myo_pkg::bus_data_t writedata;
	logic read_en;
	logic miso;
	logic mirrored;
	myo_pkg::bus_data_t readdata;
	logic waitrequest;
	logic [MOTORS-1:0] ss_n;
	logic sck;
	logic mosi;

	// raw words of the data file, the mirrored flag comes first
	logic [31:0] stim [0:MOTORS*COLUMNS];
	logic [31:0] kp [MOTORS];
	logic [31:0] kd [MOTORS];
	logic [31:0] setpoint [MOTORS];
	logic [31:0] limit [MOTORS];
	logic [31:0] mode [MOTORS];
	logic [31:0] position [MOTORS];
	logic [31:0] disp [MOTORS];
	logic [31:0] file_pwm [MOTORS];
	// reference results of the first and the second sweep
	logic [15:0] pwm_first [MOTORS];
	logic [15:0] pwm_second [MOTORS];

	// state of the SPI slave model
	int frame_count;
	int cur_frame;
	int sel_motor;
	int rx_bits;
	logic [MOTORS-1:0] sel_expect;
	logic [63:0] slave_tx;
	logic [15:0] rx_word;
	logic [15:0] word0_log [16];
	logic sck_prev;
	logic [MOTORS-1:0] ss_prev;

	myo_control DUT (
		.clock(clock),
		.reset(reset),
		.address_i(address),
		.write_i(write_en),
		.writedata_i(writedata),
		.read_i(read_en),
		.miso_i(miso),
		.mirrored_muscle_unit_i(mirrored),
		.readdata_o(readdata),
		.waitrequest_o(waitrequest),
		.ss_n_o(ss_n),
		.sck_o(sck),
		.mosi_o(mosi)
	);

	always #20 clock = ~clock;

	task automatic stop_on_failure(input string what);
		$display("%s", what);
		$display("Result: FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic check(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			stop_on_failure($sformatf("ERROR %s: got 0x%08h, expected 0x%08h",
				name, actual, expected));
		end
	endtask

	function automatic myo_pkg::bus_addr_t addr_of(input logic [7:0] sel, input int m);
		return {sel, 8'(m)};
	endfunction

	// displacement as the hub stores it, flipped for a mirrored unit
	function automatic logic [15:0] seen_disp(input int m);
		logic [15:0] d;
		d = disp[m][15:0];
		if (mirrored) begin
			d = -d;
		end
		return d;
	endfunction

	// feedback the PD law regulates, picked by the motor's mode
	function automatic int feedback_of(input int m);
		logic signed [15:0] d;
		d = seen_disp(m);
		if (mode[m] == 32'd1) begin
			return int'(d);
		end
		return int'(position[m]);
	endfunction

	// PD law with 64-bit products, arithmetic shift and a magnitude clamp
	function automatic logic [15:0] pd_expected(input int gp, input int gd, input int err,
		input int derr, input int lim);
		longint sum;
		longint scaled;
		longint cap;
		sum = longint'(gp) * longint'(err) + longint'(gd) * longint'(derr);
		scaled = sum >>> `MYO_GAIN_SHIFT;
		cap = (lim < 0) ? -longint'(lim) : longint'(lim);
		if (cap > `MYO_PWM_MAX) begin
			cap = `MYO_PWM_MAX;
		end
		if (scaled > cap) begin
			scaled = cap;
		end else if (scaled < -cap) begin
			scaled = -cap;
		end
		return scaled[15:0];
	endfunction

	// what a motor board answers, word 0 is a status word the hub drops
	function automatic logic [63:0] slave_frame(input int m);
		return {16'h5A5A, position[m], disp[m][15:0]};
	endfunction

	task automatic bus_write(input myo_pkg::bus_addr_t addr, input logic [31:0] data);
		@(posedge clock);
		address <= addr;
		writedata <= data;
		write_en <= 1'b1;
		@(posedge clock);
		write_en <= 1'b0;
	endtask

	// holds the read until waitrequest drops and counts the stall cycles
	task automatic bus_read(input myo_pkg::bus_addr_t addr, output logic [31:0] data);
		int cycles;
		int stalls;
		cycles = 0;
		stalls = 0;
		@(posedge clock);
		address <= addr;
		read_en <= 1'b1;
		do begin
			@(posedge clock);
			cycles++;
			if (waitrequest) begin
				stalls++;
			end
			if (cycles > 16) begin
				stop_on_failure("a bus read timed out waiting for waitrequest to drop");
			end
		end while (waitrequest);
		data = readdata;
		read_en <= 1'b0;
		check("waitrequest_o cycles", stalls, 1);
	endtask

	task automatic read_check(input string name, input myo_pkg::bus_addr_t addr,
		input logic [31:0] expected);
		logic [31:0] data;
		bus_read(addr, data);
		check(name, data, expected);
	endtask

	task automatic wait_frames(input int count);
		int cycles;
		cycles = 0;
		while (frame_count < count) begin
			@(posedge clock);
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				stop_on_failure($sformatf("timed out waiting for SPI frame %0d", count));
			end
		end
	endtask

	task automatic wait_select_release();
		int cycles;
		cycles = 0;
		while (ss_n != '1) begin
			@(posedge clock);
			cycles++;
			if (cycles > FRAME_LEN + 16) begin
				stop_on_failure("timed out waiting for the last SPI frame to end");
			end
		end
	endtask

	task automatic expect_quiet_bus(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(posedge clock);
			if (ss_n != '1) begin
				stop_on_failure("a slave select went low after run was cleared");
			end
		end
	endtask

	// SPI slave model, it watches the wire at every clock edge
	always @(posedge clock) begin
		if (reset) begin
			frame_count <= 0;
			ss_prev <= '1;
			sck_prev <= 1'b0;
			miso <= 1'b0;
		end else begin
			ss_prev <= ss_n;
			sck_prev <= sck;
			// a new frame must select the next motor of the round robin
			if ((ss_prev & ~ss_n) != '0) begin
				sel_motor = frame_count % MOTORS;
				sel_expect = '1;
				sel_expect[sel_motor] = 1'b0;
				check("ss_n_o", 32'(ss_n), 32'(sel_expect));
				slave_tx = slave_frame(sel_motor);
				cur_frame = frame_count;
				rx_bits = 0;
				frame_count <= frame_count + 1;
			end
			// miso leaves on sck rise, the master takes it on the fall
			if (sck && !sck_prev) begin
				miso <= slave_tx[63];
				slave_tx = {slave_tx[62:0], 1'b0};
			end
			// only word 0 of mosi carries data
			if (!sck && sck_prev && rx_bits < 16) begin
				rx_word = {rx_word[14:0], mosi};
				rx_bits++;
				if (rx_bits == 16 && cur_frame < 16) begin
					word0_log[cur_frame] <= rx_word;
				end
			end
		end
	end

	initial begin
		int base;
		int err;
		logic [15:0] expect_word;
		logic [15:0] disp_seen;
		$readmemh("tests/myo_control_input.txt", stim);
		for (int i = 0; i < MOTORS; i++) begin
			base = 1 + COLUMNS * i;
			kp[stim[base]] = stim[base + 1];
			kd[stim[base]] = stim[base + 2];
			setpoint[stim[base]] = stim[base + 3];
			limit[stim[base]] = stim[base + 4];
			mode[stim[base]] = stim[base + 5];
			position[stim[base]] = stim[base + 6];
			disp[stim[base]] = stim[base + 7];
			file_pwm[stim[base]] = stim[base + 8];
		end
		clock = 1'b0;
		reset = 1'b1;
		address = '0;
		write_en = 1'b0;
		writedata = '0;
		read_en = 1'b0;
		miso = 1'b0;
		mirrored = stim[0][0];
		repeat (8) @(posedge clock);
		reset <= 1'b0;

		// the boards answer the same sample every frame, so the second
		// sweep sees a zero error difference
		for (int m = 0; m < MOTORS; m++) begin
			err = int'(setpoint[m]) - feedback_of(m);
			pwm_first[m] = pd_expected(kp[m], kd[m], err, err, limit[m]);
			pwm_second[m] = pd_expected(kp[m], kd[m], err, 0, limit[m]);
			check($sformatf("reference pwm[%0d]", m),
				{{16{pwm_first[m][15]}}, pwm_first[m]}, file_pwm[m]);
		end

		for (int m = 0; m < MOTORS; m++) begin
			bus_write(addr_of(`MYO_ADDR_KP, m), kp[m]);
			bus_write(addr_of(`MYO_ADDR_KD, m), kd[m]);
			bus_write(addr_of(`MYO_ADDR_SP, m), setpoint[m]);
			bus_write(addr_of(`MYO_ADDR_LIMIT, m), limit[m]);
			bus_write(addr_of(`MYO_ADDR_MODE, m), mode[m]);
		end
		for (int m = 0; m < MOTORS; m++) begin
			read_check($sformatf("readdata_o kp[%0d]", m), addr_of(`MYO_ADDR_KP, m), kp[m]);
			read_check($sformatf("readdata_o kd[%0d]", m), addr_of(`MYO_ADDR_KD, m), kd[m]);
			read_check($sformatf("readdata_o setpoint[%0d]", m), addr_of(`MYO_ADDR_SP, m),
				setpoint[m]);
			read_check($sformatf("readdata_o limit[%0d]", m), addr_of(`MYO_ADDR_LIMIT, m),
				limit[m]);
			read_check($sformatf("readdata_o mode[%0d]", m), addr_of(`MYO_ADDR_MODE, m),
				mode[m]);
		end
		read_check("readdata_o bad motor", addr_of(`MYO_ADDR_KP, MOTORS), `MYO_BAD_READ);
		read_check("readdata_o bad selector", addr_of(8'h01, 0), `MYO_BAD_READ);
		read_check("readdata_o run", addr_of(`MYO_ADDR_RUN, 0), 32'd0);

		// first sweep, all motors are computed once frame 4 has begun
		bus_write(addr_of(`MYO_ADDR_RUN, 0), 32'd1);
		wait_frames(MOTORS + 1);
		for (int m = 0; m < MOTORS; m++) begin
			disp_seen = seen_disp(m);
			read_check($sformatf("readdata_o position[%0d]", m),
				addr_of(`MYO_ADDR_POSITION, m), position[m]);
			read_check($sformatf("readdata_o displacement[%0d]", m),
				addr_of(`MYO_ADDR_DISPLACEMENT, m),
				{{16{disp_seen[15]}}, disp_seen});
			read_check($sformatf("readdata_o pwm[%0d]", m), addr_of(`MYO_ADDR_PWM, m),
				{{16{pwm_first[m][15]}}, pwm_first[m]});
		end

		// second sweep brings the previous error into the derivative term
		wait_frames(2 * MOTORS + 1);
		for (int m = 0; m < MOTORS; m++) begin
			read_check($sformatf("readdata_o pwm[%0d] sweep 2", m),
				addr_of(`MYO_ADDR_PWM, m), {{16{pwm_second[m][15]}}, pwm_second[m]});
		end

		// stopping lets the frame in flight finish and starts no other
		bus_write(addr_of(`MYO_ADDR_RUN, 0), 32'd0);
		wait_select_release();
		expect_quiet_bus(3 * FRAME_LEN);
		check("frame count", frame_count, 2 * MOTORS + 1);

		// each frame sends the reference computed in the sweep before
		for (int f = 0; f <= 2 * MOTORS; f++) begin
			if (f < MOTORS) begin
				expect_word = '0;
			end else if (f < 2 * MOTORS) begin
				expect_word = pwm_first[f % MOTORS];
			end else begin
				expect_word = pwm_second[f % MOTORS];
			end
			check($sformatf("mosi_o word 0 of frame %0d", f), word0_log[f], expect_word);
		end

		$display("Result: PASSED");
		$finish;
	end

endmodule
